// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = aluSystemTb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+tests
hw/aluPkg.sv
hw/regFile.sv
hw/arithLogicUnit.sv
hw/opSequencer.sv
hw/aluSystem.sv
tests/aluSystemTb.sv

// ==== hw/aluPkg.sv ====
// Widths, function codes and bus structs shared by the command-driven ALU unit
// Every RTL module refers to these by scoped name
package aluPkg;

    localparam int dataWidth   = 8;
    localparam int numRegs     = 4;
    localparam int regIdxWidth = 2;

    typedef logic [dataWidth-1:0]   dataT;
    typedef logic [regIdxWidth-1:0] regIdxT;

    // Register function codes
    typedef enum logic [1:0] {
        regDec   = 2'b00,
        regInc   = 2'b01,
        regLoad  = 2'b10,
        regClear = 2'b11
    } regFunT;

    typedef enum logic [3:0] {
        aluPassA = 4'b0000,
        aluPassB = 4'b0001,
        aluNotA  = 4'b0010,
        aluNotB  = 4'b0011,
        aluAdd   = 4'b0100,
        aluAddC  = 4'b0101,
        aluSub   = 4'b0110,
        aluAnd   = 4'b0111,
        aluOr    = 4'b1000,
        aluXor   = 4'b1001,
        aluLsl   = 4'b1010,
        aluLsr   = 4'b1011,
        aluAsl   = 4'b1100,
        aluAsr   = 4'b1101,
        aluRolC  = 4'b1110, // Rotate through carry
        aluRorC  = 4'b1111
    } aluFunT;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flagsT;

    typedef struct packed {
        logic   isAlu;   // 1 selects ALU op, 0 a register function
        regFunT regFun;
        aluFunT aluFun;
        regIdxT dest;
        regIdxT srcA;
        regIdxT srcB;
        dataT   imm;     // Load value for regLoad
        logic [2:0] spare;
    } cmdT;

    typedef struct packed {
        dataT  value;
        flagsT flags;
    } resultT;

    // Next value of a register under one of the four register functions
    function automatic dataT applyRegFun(regFunT fun, dataT cur, dataT imm);
        dataT next;
        case (fun)
            regDec:   next = cur - dataT'(1); // Wraps at zero
            regInc:   next = cur + dataT'(1);
            regLoad:  next = imm;
            default:  next = '0;
        endcase
        return next;
    endfunction

endpackage

// ==== hw/aluSystem.sv ====
// Top level of the execution unit with valid/ready command and result channels
// Register reads feed the ALU, and the sequencer retires the command
`timescale 1ns/1ps

module aluSystem (
    input  logic           clock,
    input  logic           arstN,
    input  aluPkg::cmdT    cmd,
    input  logic           cmdValid,
    output logic           cmdReady,
    output aluPkg::resultT res,
    output logic           resValid,
    input  logic           resReady
);

    aluPkg::regIdxT rdIdxA;
    aluPkg::dataT   rdA;
    aluPkg::dataT   rdB;
    aluPkg::dataT   aluValue;
    aluPkg::flagsT  aluFlags;
    aluPkg::flagsT  flags;
    logic           wrEn;
    aluPkg::regIdxT wrIdx;
    aluPkg::regFunT wrFun;
    aluPkg::dataT   wrData;

    // Port A reads the destination for register functions
    assign rdIdxA = cmd.isAlu ? cmd.srcA : cmd.dest;

    regFile uRegFile (
        .clock  (clock),
        .arstN  (arstN),
        .rdIdxA (rdIdxA),
        .rdIdxB (cmd.srcB),
        .wrEn   (wrEn),
        .wrIdx  (wrIdx),
        .wrFun  (wrFun),
        .wrData (wrData),
        .rdA    (rdA),
        .rdB    (rdB)
    );

    arithLogicUnit uAlu (
        .a        (rdA),
        .b        (rdB),
        .fun      (cmd.aluFun),
        .carryIn  (flags.carry),
        .flagsIn  (flags),
        .value    (aluValue),
        .flagsOut (aluFlags)
    );

    opSequencer uSeq (
        .clock    (clock),
        .arstN    (arstN),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .resReady (resReady),
        .aluValue (aluValue),
        .aluFlags (aluFlags),
        .rdDest   (rdA),
        .cmdReady (cmdReady),
        .res      (res),
        .resValid (resValid),
        .flags    (flags),
        .wrEn     (wrEn),
        .wrIdx    (wrIdx),
        .wrFun    (wrFun),
        .wrData   (wrData)
    );

endmodule

// ==== hw/arithLogicUnit.sv ====
// Combinational 16-function ALU with zero, carry, negative and overflow flags
// Flags a function does not touch pass through from flagsIn
`timescale 1ns/1ps

module arithLogicUnit (
    input  aluPkg::dataT   a,
    input  aluPkg::dataT   b,
    input  aluPkg::aluFunT fun,
    input  logic           carryIn,
    input  aluPkg::flagsT  flagsIn,
    output aluPkg::dataT   value,
    output aluPkg::flagsT  flagsOut
);

    localparam int msb = aluPkg::dataWidth - 1;

    logic [aluPkg::dataWidth:0] wide; // Result with carry or borrow on top
    aluPkg::dataT  result;
    aluPkg::flagsT next;

    always_comb begin
        wide   = '0;
        result = a;
        next   = flagsIn;

        case (fun)
            aluPkg::aluPassA: result = a;
            aluPkg::aluPassB: result = b;
            aluPkg::aluNotA:  result = ~a;
            aluPkg::aluNotB:  result = ~b;
            aluPkg::aluAdd: begin
                wide          = {1'b0, a} + {1'b0, b};
                result        = wide[msb:0];
                next.carry    = wide[msb+1];
                next.overflow = ~(a[msb] ^ b[msb]) & (a[msb] ^ result[msb]);
            end
            aluPkg::aluAddC: begin
                wide          = {1'b0, a} + {1'b0, b} + (aluPkg::dataWidth+1)'(carryIn);
                result        = wide[msb:0];
                next.carry    = wide[msb+1];
                next.overflow = ~(a[msb] ^ b[msb]) & (a[msb] ^ result[msb]);
            end
            aluPkg::aluSub: begin
                wide          = {1'b0, a} - {1'b0, b};
                result        = wide[msb:0];
                next.carry    = wide[msb+1]; // Borrow out
                next.overflow = (a[msb] ^ b[msb]) & (a[msb] ^ result[msb]);
            end
            aluPkg::aluAnd:   result = a & b;
            aluPkg::aluOr:    result = a | b;
            aluPkg::aluXor:   result = a ^ b;
            aluPkg::aluLsl: begin
                result     = {a[msb-1:0], 1'b0};
                next.carry = a[msb];
            end
            aluPkg::aluLsr: begin
                result     = {1'b0, a[msb:1]};
                next.carry = a[0];
            end
            aluPkg::aluAsl: begin
                result        = {a[msb-1:0], 1'b0};
                next.carry    = a[msb];
                next.overflow = a[msb] ^ a[msb-1];
            end
            aluPkg::aluAsr:   result = {a[msb], a[msb:1]}; // Sign kept, carry untouched
            aluPkg::aluRolC: begin
                result        = {a[msb-1:0], carryIn};
                next.carry    = a[msb];
                next.overflow = a[msb] ^ a[msb-1];
            end
            aluPkg::aluRorC: begin
                result        = {carryIn, a[msb:1]};
                next.carry    = a[0];
                next.overflow = a[msb] ^ carryIn;
            end
        endcase

        // Every function updates zero and negative
        next.zero     = (result == '0);
        next.negative = result[msb];
    end

    assign value    = result;
    assign flagsOut = next;

endmodule

// ==== hw/opSequencer.sv ====
// Command acceptance, flag register, register writeback and the result register
// A command taken at one edge has its result valid right after that edge
`timescale 1ns/1ps

module opSequencer (
    input  logic           clock,
    input  logic           arstN,
    input  aluPkg::cmdT    cmd,
    input  logic           cmdValid,
    input  logic           resReady,
    input  aluPkg::dataT   aluValue,
    input  aluPkg::flagsT  aluFlags,
    input  aluPkg::dataT   rdDest,   // Current destination value via read port A
    output logic           cmdReady,
    output aluPkg::resultT res,
    output logic           resValid,
    output aluPkg::flagsT  flags,
    output logic           wrEn,
    output aluPkg::regIdxT wrIdx,
    output aluPkg::regFunT wrFun,
    output aluPkg::dataT   wrData
);

    logic         accept;
    aluPkg::dataT nextValue;

    // One result in flight, so a free or draining slot takes a new command
    assign cmdReady = !resValid || resReady;
    assign accept   = cmdValid && cmdReady;

    // ALU results go back through a load
    assign wrEn   = accept;
    assign wrIdx  = cmd.dest;
    assign wrFun  = cmd.isAlu ? aluPkg::regLoad : cmd.regFun;
    assign wrData = cmd.isAlu ? aluValue : cmd.imm;

    assign nextValue = cmd.isAlu ? aluValue
                                 : aluPkg::applyRegFun(cmd.regFun, rdDest, cmd.imm);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            flags    <= '0;
            resValid <= 1'b0;
        end else begin
            if (accept && cmd.isAlu) begin
                flags <= aluFlags;
            end
            if (accept) begin
                resValid <= 1'b1;
            end else if (resReady) begin
                resValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            res.value <= nextValue;
            res.flags <= cmd.isAlu ? aluFlags : flags; // Register functions keep flags
        end
    end

endmodule

// ==== hw/regFile.sv ====
// Four general registers with two combinational read ports
// The single write port applies a register function to the indexed register
`timescale 1ns/1ps

module regFile (
    input  logic           clock,
    input  logic           arstN,
    input  aluPkg::regIdxT rdIdxA,
    input  aluPkg::regIdxT rdIdxB,
    input  logic           wrEn,
    input  aluPkg::regIdxT wrIdx,
    input  aluPkg::regFunT wrFun,
    input  aluPkg::dataT   wrData,
    output aluPkg::dataT   rdA,
    output aluPkg::dataT   rdB
);

    aluPkg::dataT regs [aluPkg::numRegs];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < aluPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= aluPkg::applyRegFun(wrFun, regs[wrIdx], wrData);
        end
    end

    // Read muxes
    assign rdA = regs[rdIdxA];
    assign rdB = regs[rdIdxB];

endmodule

// ==== tests/aluModel.svh ====
// Reference model of the register functions and of the ALU with its flags
// The testbench that includes it keeps the register and flag state
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic aluPkg::dataT modelReg(aluPkg::regFunT fun, aluPkg::dataT cur,
                                          aluPkg::dataT imm);
    case (fun)
        aluPkg::regDec:  return cur - 8'd1;
        aluPkg::regInc:  return cur + 8'd1;
        aluPkg::regLoad: return imm;
        default:         return 8'd0;
    endcase
endfunction

function automatic aluPkg::resultT modelAlu(aluPkg::aluFunT fun, aluPkg::dataT a,
                                            aluPkg::dataT b, aluPkg::flagsT old);
    aluPkg::resultT r;
    logic [8:0] sum;
    r.flags = old;
    r.value = a;
    sum = 9'd0;
    case (fun)
        aluPkg::aluPassB: r.value = b;
        aluPkg::aluNotA:  r.value = ~a;
        aluPkg::aluNotB:  r.value = ~b;
        aluPkg::aluAdd, aluPkg::aluAddC: begin
            sum = {1'b0, a} + {1'b0, b} + 9'((fun == aluPkg::aluAddC) ? old.carry : 1'b0);
            r.value = sum[7:0];
            r.flags.carry = sum[8];
            r.flags.overflow = (a[7] == b[7]) && (r.value[7] != a[7]);
        end
        aluPkg::aluSub: begin
            r.value = a - b;
            r.flags.carry = (a < b); // Borrow
            r.flags.overflow = (a[7] != b[7]) && (r.value[7] != a[7]);
        end
        aluPkg::aluAnd: r.value = a & b;
        aluPkg::aluOr:  r.value = a | b;
        aluPkg::aluXor: r.value = a ^ b;
        aluPkg::aluLsl, aluPkg::aluAsl: begin
            r.value = a << 1;
            r.flags.carry = a[7];
            if (fun == aluPkg::aluAsl) r.flags.overflow = a[7] ^ a[6];
        end
        aluPkg::aluLsr: begin
            r.value = a >> 1;
            r.flags.carry = a[0];
        end
        aluPkg::aluAsr: r.value = {a[7], a[7:1]};
        aluPkg::aluRolC: begin
            r.value = {a[6:0], old.carry};
            r.flags.carry = a[7];
            r.flags.overflow = a[7] ^ a[6];
        end
        aluPkg::aluRorC: begin
            r.value = {old.carry, a[7:1]};
            r.flags.carry = a[0];
            r.flags.overflow = a[7] ^ old.carry;
        end
        default: r.value = a;
    endcase
    r.flags.zero = (r.value == 8'd0);
    r.flags.negative = r.value[7];
    return r;
endfunction

`endif

// ==== tests/aluSystemTb.sv ====
// Testbench for aluSystem with directed and random commands checked against a model
// Every result transfer is compared with the model's queued expectation
`timescale 1ns/1ps

module aluSystemTb;
    `include "aluModel.svh"

    localparam int randCmds = 60;
    localparam int chainCmds = 40;
    // Reset readback, register functions, two ALU sweeps, flag cases, random, chained
    localparam int numCmds = 2 * aluPkg::numRegs + 9 + 2 * 16 * 4 + 15 * 3
                           + randCmds + chainCmds;
    localparam time watchdogNs = numCmds * 40 * 8;

    logic clock = 1'b0;
    logic arstN;
    aluPkg::cmdT cmd;
    logic cmdValid;
    logic cmdReady;
    aluPkg::resultT res;
    logic resValid;
    logic resReady;
    int seed = 91383;
    logic throttle; // Randomizes resReady while set
    aluPkg::dataT modelRegs [aluPkg::numRegs];
    aluPkg::flagsT modelFlags;
    aluPkg::resultT expQ [$];

    always #20 clock = ~clock;

    aluSystem DUT (
        .clock    (clock),
        .arstN    (arstN),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .res      (res),
        .resValid (resValid),
        .resReady (resReady)
    );

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    function automatic aluPkg::cmdT regCmd(aluPkg::regFunT fun, int dest, aluPkg::dataT imm);
        aluPkg::cmdT c;
        c = '0;
        c.regFun = fun;
        c.dest = aluPkg::regIdxT'(dest);
        c.imm = imm;
        return c;
    endfunction

    function automatic aluPkg::cmdT aluCmd(aluPkg::aluFunT fun, int dest, int srcA, int srcB);
        aluPkg::cmdT c;
        c = '0;
        c.isAlu = 1'b1;
        c.aluFun = fun;
        c.dest = aluPkg::regIdxT'(dest);
        c.srcA = aluPkg::regIdxT'(srcA);
        c.srcB = aluPkg::regIdxT'(srcB);
        return c;
    endfunction

    function automatic aluPkg::cmdT randomCmd();
        aluPkg::cmdT c;
        c = aluPkg::cmdT'(24'($random(seed)));
        c.spare = '0;
        return c;
    endfunction

    // Holds the command until the edge where it is taken
    task automatic issue(input aluPkg::cmdT c);
        cmd <= c;
        cmdValid <= 1'b1;
        do begin
            if (throttle) resReady <= ($random(seed) & 3) != 0;
            @(posedge clock);
        end while (!cmdReady);
    endtask

    task automatic runPair(aluPkg::aluFunT fun, aluPkg::dataT x, aluPkg::dataT y);
        issue(regCmd(aluPkg::regLoad, 0, x));
        issue(regCmd(aluPkg::regLoad, 1, y));
        issue(aluCmd(fun, 2, 0, 1));
    endtask

    always @(posedge clock) begin : scoreboard
        aluPkg::resultT expected;
        logic pending;
        if (arstN) begin
            pending = expQ.size() != 0; // A result is owed by the DUT
            assert (resValid === pending) else stopOnError($sformatf(
                "error at %0t ns: resValid expected %b, got %b", $time, pending, resValid));
            assert (cmdReady === (!pending || resReady)) else stopOnError($sformatf(
                "error at %0t ns: cmdReady expected %b, got %b", $time,
                !pending || resReady, cmdReady));
        end
        if (arstN && resValid && resReady) begin
            expected = expQ.pop_front();
            assert (res === expected) else stopOnError($sformatf(
                "error at %0t ns: res expected %h, got %h", $time, expected, res));
        end
        if (arstN && cmdValid && cmdReady) begin
            if (cmd.isAlu) begin
                expected = modelAlu(cmd.aluFun, modelRegs[cmd.srcA], modelRegs[cmd.srcB],
                                    modelFlags);
                modelFlags = expected.flags;
            end else begin
                expected.value = modelReg(cmd.regFun, modelRegs[cmd.dest], cmd.imm);
                expected.flags = modelFlags;
            end
            modelRegs[cmd.dest] = expected.value;
            expQ.push_back(expected);
        end
    end

    initial begin : stimulus
        aluPkg::cmdT c;
        int prevDest;
        cmd = '0;
        cmdValid = 1'b0;
        resReady = 1'b1;
        throttle = 1'b0;
        arstN = 1'b0;
        modelFlags = '0;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        repeat (2) @(posedge clock);
        arstN <= 1'b1;
        @(posedge clock);

        // 255 then 0 from each register proves the reset clear
        for (int r = 0; r < aluPkg::numRegs; r++) begin
            issue(regCmd(aluPkg::regDec, r, 8'h00));
            issue(regCmd(aluPkg::regInc, r, 8'h00));
        end

        runPair(aluPkg::aluSub, 8'h00, 8'h01); // Nonzero flags for the register functions
        issue(regCmd(aluPkg::regLoad, 3, 8'hFF));
        issue(regCmd(aluPkg::regInc, 3, 8'h00));
        issue(regCmd(aluPkg::regDec, 3, 8'h00));
        issue(regCmd(aluPkg::regLoad, 3, aluPkg::dataT'($random(seed))));
        issue(regCmd(aluPkg::regInc, 3, 8'h00));
        issue(regCmd(aluPkg::regClear, 3, 8'h5A));

        repeat (2) begin
            for (int f = 0; f < 16; f++) begin
                runPair(aluPkg::aluFunT'(f), aluPkg::dataT'($random(seed)),
                        aluPkg::dataT'($random(seed)));
                issue(aluCmd(aluPkg::aluPassA, 3, 2, 0)); // Reads back r2
            end
        end

        // Flag boundaries and carry into add-with-carry and the rotates
        runPair(aluPkg::aluXor, 8'h5A, 8'h5A);
        runPair(aluPkg::aluAdd, 8'h7F, 8'h01);
        runPair(aluPkg::aluAdd, 8'h80, 8'h80);
        runPair(aluPkg::aluAdd, 8'hFF, 8'h01);
        runPair(aluPkg::aluAddC, 8'h10, 8'h20);
        runPair(aluPkg::aluSub, 8'h80, 8'h01);
        runPair(aluPkg::aluSub, 8'h7F, 8'hFF);
        runPair(aluPkg::aluRolC, 8'h41, 8'h00);
        runPair(aluPkg::aluSub, 8'h00, 8'h01);
        runPair(aluPkg::aluRorC, 8'h02, 8'h00);
        runPair(aluPkg::aluRorC, 8'h81, 8'h00);
        runPair(aluPkg::aluRolC, 8'h80, 8'h00);
        runPair(aluPkg::aluSub, 8'h33, 8'h33);
        runPair(aluPkg::aluAddC, 8'hFF, 8'h00);
        runPair(aluPkg::aluRolC, 8'h80, 8'h00);

        throttle = 1'b1;
        repeat (randCmds) issue(randomCmd());
        throttle = 1'b0;
        resReady <= 1'b1;

        // Each source A is the previous destination
        prevDest = 0;
        repeat (chainCmds) begin
            c = randomCmd();
            c.isAlu = 1'b1;
            c.srcA = aluPkg::regIdxT'(prevDest);
            prevDest = c.dest;
            issue(c);
        end
        cmdValid <= 1'b0;

        // Drain the last result
        do begin
            @(posedge clock);
        end while (resValid);

        if (expQ.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stopOnError($sformatf("%0d results never arrived", expQ.size()));
        end
    end

    initial begin : watchdog
        #(watchdogNs);
        stopOnError($sformatf("Timeout at %0t ns, the DUT stopped responding", $time));
    end

endmodule
